/* rv_core.f */
common/isa_pkg.sv
common/mem_pkg.sv
design/ifu.sv
design/idu.sv
design/exu.sv
design/lsu.sv
design/wbu.sv
design/mem_port.sv
design/rv_core.sv
verification/tb_mem.sv
verification/tb_rv_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= rv_core.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verification/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;

  localparam logic [31:0] RESET_PC    = 32'h0000_1000;
  localparam int          MEM_CREDITS = 2;
  localparam logic [6:0]  OP_LUI = 7'h37, OP_AUIPC = 7'h17, OP_JALR = 7'h67;
  localparam logic [6:0]  OP_LOAD = 7'h03, OP_IMM = 7'h13, OP_REG = 7'h33;

  logic              clk = 1'b0;
  logic              rst_n = 1'b0;
  mem_pkg::mem_req_t mem_req;
  mem_pkg::mem_rsp_t mem_rsp;
  mem_pkg::retire_t  retire;
  logic              mem_credit, halted;

  logic [31:0] exp_pc [$];
  logic [31:0] exp_val [$];
  logic [4:0]  exp_rd [$];
  logic        exp_we [$];
  logic [31:0] m [32];
  logic [31:0] pc_w;
  int errors = 0, idx = 0, in_flight = 0, n_inst = 0;
  logic rst_q = 1'b0, seen_req = 1'b0, halt_seen = 1'b0, ready = 1'b0;

  rv_core #(.RESET_PC(RESET_PC), .MEM_CREDITS(MEM_CREDITS)) u_rv_core (
    .clk(clk), .rst_n(rst_n), .mem_req(mem_req), .mem_credit(mem_credit),
    .mem_rsp(mem_rsp), .retire(retire), .halted(halted)
  );

  tb_mem u_mem (
    .clk(clk), .rst_n(rst_n), .mem_req(mem_req), .mem_credit(mem_credit), .mem_rsp(mem_rsp)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OP_REG};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  task automatic put(input logic [31:0] word, input logic [4:0] rd, input logic we,
                     input logic [31:0] val);
    u_mem.mem[pc_w[11:2]] = word;
    exp_pc.push_back(pc_w);
    exp_rd.push_back(rd);
    exp_we.push_back(we);
    exp_val.push_back(val);
    if (we && rd != 5'd0) m[rd] = val;
    pc_w += 4;
  endtask

  // slot jumped over, addi x31 would show up as an extra retire
  task automatic skip_slot();
    u_mem.mem[pc_w[11:2]] = enc_i(12'h7ff, 5'd0, 3'd0, 5'd31, OP_IMM);
    pc_w += 4;
  endtask

  task automatic branch(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
                        input logic taken);
    put(enc_b(13'd8, rs2, rs1, f3), 5'd0, 1'b0, 32'h0);
    if (taken) skip_slot();
  endtask

  task automatic value_err(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("Error: %s got %h expected %h", name, got, exp);
    errors++;
  endtask

  task automatic build_program();
    for (int i = 0; i < 1024; i++) u_mem.mem[i] = 32'h0;
    for (int i = 0; i < 32; i++) m[i] = 32'h0;
    pc_w = RESET_PC;
    put(enc_i(12'h123, 0, 0, 1, OP_IMM), 1, 1, 32'h123);
    put(enc_i(12'hffb, 0, 0, 2, OP_IMM), 2, 1, 32'hffff_fffb);
    put(enc_r(7'h00, 2, 1, 3'd0, 3), 3, 1, m[1] + m[2]);
    put(enc_r(7'h20, 2, 1, 3'd0, 4), 4, 1, m[1] - m[2]);
    put(enc_r(7'h00, 2, 1, 3'd7, 5), 5, 1, m[1] & m[2]);
    put(enc_r(7'h00, 2, 1, 3'd6, 6), 6, 1, m[1] | m[2]);
    put(enc_r(7'h00, 2, 1, 3'd4, 7), 7, 1, m[1] ^ m[2]);
    put(enc_i(12'h004, 1, 3'd1, 8, OP_IMM), 8, 1, m[1] << 4);
    put(enc_i(12'h004, 2, 3'd5, 9, OP_IMM), 9, 1, m[2] >> 4);
    put(enc_i(12'h401, 2, 3'd5, 10, OP_IMM), 10, 1, 32'($signed(m[2]) >>> 1));
    put(enc_i(12'h003, 0, 0, 12, OP_IMM), 12, 1, 32'h3);
    put(enc_r(7'h00, 12, 1, 3'd1, 11), 11, 1, m[1] << 3);
    put(enc_r(7'h00, 12, 2, 3'd5, 13), 13, 1, m[2] >> 3);
    put(enc_r(7'h20, 12, 2, 3'd5, 14), 14, 1, 32'($signed(m[2]) >>> 3));
    put(enc_r(7'h00, 1, 2, 3'd2, 15), 15, 1, 32'h1);  // -5 < 0x123 signed
    put(enc_r(7'h00, 1, 2, 3'd3, 16), 16, 1, 32'h0);
    put(enc_i(12'hfff, 1, 3'd2, 17, OP_IMM), 17, 1, 32'h0);
    put({20'habcde, 5'd18, OP_LUI}, 18, 1, 32'habcd_e000);
    put({20'h00001, 5'd19, OP_AUIPC}, 19, 1, pc_w + 32'h1000);
    put(enc_i(12'h700, 0, 0, 20, OP_IMM), 20, 1, 32'h700);
    put(enc_s(12'd0, 7, 20, 3'd2), 0, 0, 32'h0);
    put(enc_i(12'd0, 20, 3'd2, 21, OP_LOAD), 21, 1, m[7]);
    put(enc_i(12'h080, 0, 0, 22, OP_IMM), 22, 1, 32'h80);
    put(enc_s(12'd5, 22, 20, 3'd0), 0, 0, 32'h0);
    put(enc_i(12'd5, 20, 3'd0, 23, OP_LOAD), 23, 1, 32'hffff_ff80);
    put(enc_i(12'd5, 20, 3'd4, 24, OP_LOAD), 24, 1, 32'h80);
    put({20'h00008, 5'd25, OP_LUI}, 25, 1, 32'h8000);
    put(enc_s(12'd10, 25, 20, 3'd1), 0, 0, 32'h0);
    put(enc_i(12'd10, 20, 3'd1, 26, OP_LOAD), 26, 1, 32'hffff_8000);
    put(enc_i(12'd10, 20, 3'd5, 27, OP_LOAD), 27, 1, 32'h8000);
    branch(3'd0, 1, 1, m[1] == m[1]);
    branch(3'd1, 1, 1, m[1] != m[1]);
    branch(3'd4, 2, 1, $signed(m[2]) < $signed(m[1]));
    branch(3'd5, 2, 1, $signed(m[2]) >= $signed(m[1]));
    branch(3'd6, 1, 2, m[1] < m[2]);
    branch(3'd7, 1, 2, m[1] >= m[2]);
    put(enc_j(21'd8, 28), 28, 1, pc_w + 4);
    skip_slot();
    put({20'h0, 5'd29, OP_AUIPC}, 29, 1, pc_w);
    put(enc_i(12'd12, 29, 3'd0, 30, OP_JALR), 30, 1, pc_w + 4);  // lands at auipc pc + 12
    skip_slot();
    put(32'h0010_0073, 0, 0, 32'h0);  // ebreak
    n_inst = exp_pc.size();
  endtask

  always @(negedge clk) begin
    if (!rst_n || !rst_q) begin
      assert (!mem_req.valid && !retire.valid && !halted)
        else begin
          $display("outputs active during or right after reset");
          errors++;
        end
    end
    rst_q <= rst_n;
    if (rst_n) begin
      in_flight = in_flight + int'(mem_req.valid) - int'(mem_credit);
      assert (in_flight <= MEM_CREDITS)
        else begin
          $display("more requests in flight than credits allow");
          errors++;
        end
      if (mem_req.valid && !seen_req) begin
        seen_req = 1'b1;
        assert (mem_req.addr == RESET_PC && !mem_req.write)
          else value_err("mem_req.addr", mem_req.addr, RESET_PC);
      end
      if (halt_seen) begin
        assert (halted && !mem_req.valid && !retire.valid)
          else begin
            $display("core left halt or issued activity after ebreak");
            errors++;
          end
      end
      if (retire.valid && idx >= n_inst) begin
        $display("retire beyond the end of the program at pc %h", retire.pc);
        errors++;
      end else if (retire.valid) begin
        assert (retire.pc == exp_pc[idx]) else value_err("retire.pc", retire.pc, exp_pc[idx]);
        assert (retire.we == exp_we[idx]) else value_err("retire.we", retire.we, exp_we[idx]);
        if (exp_we[idx]) begin
          assert (retire.rd == exp_rd[idx]) else value_err("retire.rd", retire.rd, exp_rd[idx]);
          assert (retire.wdata == exp_val[idx])
            else value_err("retire.wdata", retire.wdata, exp_val[idx]);
        end
        idx++;
      end
      if (halted) halt_seen = 1'b1;
    end
  end

  initial begin
    wait (ready);
    repeat (40 * n_inst * 4) @(posedge clk);
    $display("timeout, core did not halt after %0d retires", idx);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    build_program();
    ready = 1'b1;
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;
    wait (halted);
    repeat (10) @(posedge clk);
    if (idx != n_inst) begin
      $display("only %0d of %0d instructions retired", idx, n_inst);
      errors++;
    end
    $display("errors %0d, retired %0d of %0d", errors, idx, n_inst);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* verification/tb_mem.sv */
`timescale 1ns/1ps

module tb_mem (
  input  logic              clk,
  input  logic              rst_n,
  input  mem_pkg::mem_req_t mem_req,
  output logic              mem_credit,
  output mem_pkg::mem_rsp_t mem_rsp
);

  logic [31:0] mem [1024];  // word array aliased on addr[11:2]
  logic [31:0] rng = 32'h577b_bc6d;
  int          cyc = 0;
  int          hold = 0;
  int          rsp_due [$];
  int          cred_due [$];
  logic [31:0] rsp_data [$];

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  initial begin
    mem_credit = 1'b0;
    mem_rsp    = '0;
  end

  // request is stable mid-cycle
  always @(negedge clk) begin
    if (rst_n && mem_req.valid) begin
      for (int b = 0; b < 4; b++) begin
        if (mem_req.write && mem_req.wstrb[b])
          mem[mem_req.addr[11:2]][8*b +: 8] = mem_req.wdata[8*b +: 8];
      end
      rsp_data.push_back(mem[mem_req.addr[11:2]]);
      rng = lcg_next(rng);
      rsp_due.push_back(cyc + 1 + int'(rng[17:16]));  // 1 to 4 cycles
      rng = lcg_next(rng);
      cred_due.push_back(cyc + int'(rng[21:20]));  // 0 to 3 cycles past the earliest slot
    end
  end

  always @(posedge clk) begin
    #1;
    cyc++;
    mem_rsp    = '0;
    mem_credit = 1'b0;
    rng = lcg_next(rng);
    if (hold > 0) begin
      hold--;
    end else if (rng[31:29] == 3'd0) begin
      hold = 4 + int'(rng[27:25]);  // credits withheld 4 to 11 cycles
    end
    if (rsp_due.size() > 0 && rsp_due[0] <= cyc) begin
      void'(rsp_due.pop_front());
      mem_rsp.valid = 1'b1;
      mem_rsp.rdata = rsp_data.pop_front();
    end
    if (hold == 0 && cred_due.size() > 0 && cred_due[0] < cyc) begin
      void'(cred_due.pop_front());
      mem_credit = 1'b1;
    end
  end

endmodule

/* design/rv_core.sv */
`timescale 1ns/1ps

module rv_core #(
  parameter logic [31:0] RESET_PC    = 32'h8000_0000,
  parameter int          MEM_CREDITS = 2
) (
  input  logic               clk,
  input  logic               rst_n,
  output mem_pkg::mem_req_t  mem_req,
  input  logic               mem_credit,
  input  mem_pkg::mem_rsp_t  mem_rsp,
  output mem_pkg::retire_t   retire,
  output logic               halted
);

  mem_pkg::mem_req_t fetch_req, lsu_req;
  mem_pkg::mem_rsp_t fetch_rsp, lsu_rsp;
  logic              fetch_grant, lsu_grant;
  isa_pkg::inst_t    inst;
  isa_pkg::ctrl_t    ctrl;
  logic [31:0]       pc, imm, rs1_val, rs2_val;
  logic [31:0]       alu_result, br_target, load_data;
  logic              br_taken, lsu_start, lsu_done;

  ifu #(.RESET_PC(RESET_PC)) u_ifu (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_req   (fetch_req),
    .fetch_grant (fetch_grant),
    .fetch_rsp   (fetch_rsp),
    .inst        (inst),
    .pc          (pc),
    .ctrl        (ctrl),
    .br_taken    (br_taken),
    .br_target   (br_target),
    .lsu_done    (lsu_done),
    .wb_data     (alu_result),
    .load_data   (load_data),
    .lsu_start   (lsu_start),
    .retire      (retire),
    .halted      (halted)
  );

  idu u_idu (.inst(inst), .ctrl(ctrl), .imm(imm));

  exu u_exu (
    .ctrl       (ctrl),
    .rs1_val    (rs1_val),
    .rs2_val    (rs2_val),
    .imm        (imm),
    .pc         (pc),
    .alu_result (alu_result),
    .br_taken   (br_taken),
    .br_target  (br_target)
  );

  lsu u_lsu (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (lsu_start),
    .ctrl      (ctrl),
    .addr      (alu_result),
    .store_val (rs2_val),
    .lsu_req   (lsu_req),
    .lsu_grant (lsu_grant),
    .lsu_rsp   (lsu_rsp),
    .load_data (load_data),
    .done      (lsu_done)
  );

  wbu u_wbu (
    .clk     (clk),
    .rst_n   (rst_n),
    .rs1     (ctrl.rs1),
    .rs2     (ctrl.rs2),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val),
    .retire  (retire)
  );

  mem_port #(.MEM_CREDITS(MEM_CREDITS)) u_mem_port (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_req   (fetch_req),
    .lsu_req     (lsu_req),
    .fetch_grant (fetch_grant),
    .lsu_grant   (lsu_grant),
    .fetch_rsp   (fetch_rsp),
    .lsu_rsp     (lsu_rsp),
    .mem_req     (mem_req),
    .mem_credit  (mem_credit),
    .mem_rsp     (mem_rsp)
  );

endmodule

/* design/mem_port.sv */
`timescale 1ns/1ps

module mem_port #(
  parameter int MEM_CREDITS = 2
) (
  input  logic              clk,
  input  logic              rst_n,
  input  mem_pkg::mem_req_t fetch_req,
  input  mem_pkg::mem_req_t lsu_req,
  output logic              fetch_grant,
  output logic              lsu_grant,
  output mem_pkg::mem_rsp_t fetch_rsp,
  output mem_pkg::mem_rsp_t lsu_rsp,
  output mem_pkg::mem_req_t mem_req,
  input  logic              mem_credit,
  input  mem_pkg::mem_rsp_t mem_rsp
);

  localparam int CW = $clog2(MEM_CREDITS + 1);

  logic [CW-1:0] credits;
  logic          can_send, owner_lsu;

  assign can_send    = (credits != '0);
  assign lsu_grant   = can_send && lsu_req.valid;  // lsu wins
  assign fetch_grant = can_send && fetch_req.valid && !lsu_req.valid;

  always_comb begin
    mem_req       = lsu_req.valid ? lsu_req : fetch_req;
    mem_req.valid = lsu_grant || fetch_grant;
  end

  // responses come back in order, one outstanding
  always_comb begin
    fetch_rsp       = mem_rsp;
    fetch_rsp.valid = mem_rsp.valid && !owner_lsu;
    lsu_rsp         = mem_rsp;
    lsu_rsp.valid   = mem_rsp.valid && owner_lsu;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credits   <= CW'(MEM_CREDITS);
      owner_lsu <= 1'b0;
    end else begin
      credits <= credits + CW'(mem_credit) - CW'(mem_req.valid);
      if (mem_req.valid) owner_lsu <= lsu_grant;
    end
  end

endmodule

/* design/wbu.sv */
`timescale 1ns/1ps

module wbu (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [4:0]       rs1,
  input  logic [4:0]       rs2,
  output logic [31:0]      rs1_val,
  output logic [31:0]      rs2_val,
  input  mem_pkg::retire_t retire
);

  logic [31:0] regs [32];

  // x0 is never written, so it reads zero
  assign rs1_val = regs[rs1];
  assign rs2_val = regs[rs2];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) regs[i] <= 32'b0;
    end else if (retire.valid && retire.we && retire.rd != 5'd0) begin
      regs[retire.rd] <= retire.wdata;
    end
  end

endmodule

/* design/lsu.sv */
`timescale 1ns/1ps

module lsu (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start,
  input  isa_pkg::ctrl_t    ctrl,
  input  logic [31:0]       addr,
  input  logic [31:0]       store_val,
  output mem_pkg::mem_req_t lsu_req,
  input  logic              lsu_grant,
  input  mem_pkg::mem_rsp_t lsu_rsp,
  output logic [31:0]       load_data,
  output logic              done
);

  typedef enum logic [1:0] {L_IDLE, L_REQ, L_WAIT} lsu_state_e;

  lsu_state_e        state;
  mem_pkg::mem_req_t req_q;
  logic [1:0]        size_q, off_q;
  logic              uns_q;
  logic [31:0]       lane_data, shifted, ext;
  logic [3:0]        lane_strb;

  // replicate store data across lanes, strobe picks the live ones
  always_comb begin
    case (ctrl.size)
      2'd0: begin
        lane_data = {4{store_val[7:0]}};
        lane_strb = 4'b0001 << addr[1:0];
      end
      2'd1: begin
        lane_data = {2{store_val[15:0]}};
        lane_strb = 4'b0011 << {addr[1], 1'b0};
      end
      default: begin
        lane_data = store_val;
        lane_strb = 4'b1111;
      end
    endcase
  end

  assign shifted = lsu_rsp.rdata >> {off_q, 3'b000};

  always_comb begin
    case (size_q)
      2'd0:    ext = uns_q ? {24'b0, shifted[7:0]} : {{24{shifted[7]}}, shifted[7:0]};
      2'd1:    ext = uns_q ? {16'b0, shifted[15:0]} : {{16{shifted[15]}}, shifted[15:0]};
      default: ext = shifted;
    endcase
  end

  always_comb begin
    lsu_req       = req_q;
    lsu_req.valid = (state == L_REQ);
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= L_IDLE;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        L_IDLE: if (start) state <= L_REQ;
        L_REQ:  if (lsu_grant) state <= L_WAIT;
        L_WAIT: begin
          if (lsu_rsp.valid) begin
            state <= L_IDLE;
            done  <= 1'b1;
          end
        end
        default: state <= L_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      req_q.valid <= 1'b1;
      req_q.write <= ctrl.mem_wr;
      req_q.addr  <= {addr[31:2], 2'b00};  // word aligned
      req_q.wdata <= ctrl.mem_wr ? lane_data : 32'b0;
      req_q.wstrb <= ctrl.mem_wr ? lane_strb : 4'b0;
      size_q      <= ctrl.size;
      off_q       <= addr[1:0];
      uns_q       <= ctrl.unsigned_load;
    end
    if (state == L_WAIT && lsu_rsp.valid) load_data <= ext;
  end

endmodule

/* design/exu.sv */
`timescale 1ns/1ps

module exu (
  input  isa_pkg::ctrl_t               ctrl,
  input  logic [isa_pkg::XLEN-1:0]     rs1_val,
  input  logic [isa_pkg::XLEN-1:0]     rs2_val,
  input  logic [isa_pkg::XLEN-1:0]     imm,
  input  logic [isa_pkg::XLEN-1:0]     pc,
  output logic [isa_pkg::XLEN-1:0]     alu_result,
  output logic                         br_taken,
  output logic [isa_pkg::XLEN-1:0]     br_target
);

  logic [isa_pkg::XLEN-1:0] src1, src2;
  logic                     eq, lt, ltu;

  assign src1 = ctrl.src1_pc  ? pc  : rs1_val;
  assign src2 = ctrl.src2_imm ? imm : rs2_val;

  always_comb begin
    case (ctrl.alu_op)
      isa_pkg::ALU_SUB:  alu_result = src1 - src2;
      isa_pkg::ALU_AND:  alu_result = src1 & src2;
      isa_pkg::ALU_OR:   alu_result = src1 | src2;
      isa_pkg::ALU_XOR:  alu_result = src1 ^ src2;
      isa_pkg::ALU_SLL:  alu_result = src1 << src2[4:0];
      isa_pkg::ALU_SRL:  alu_result = src1 >> src2[4:0];
      isa_pkg::ALU_SRA:  alu_result = $signed(src1) >>> src2[4:0];
      isa_pkg::ALU_SLT:  alu_result = {31'b0, $signed(src1) < $signed(src2)};
      isa_pkg::ALU_SLTU: alu_result = {31'b0, src1 < src2};
      isa_pkg::ALU_SRC2: alu_result = src2;
      default:           alu_result = src1 + src2;
    endcase
  end

  // branches compare registers, never the immediate
  assign eq  = (rs1_val == rs2_val);
  assign lt  = $signed(rs1_val) < $signed(rs2_val);
  assign ltu = rs1_val < rs2_val;

  always_comb begin
    case (ctrl.br_op)
      isa_pkg::BR_EQ:   br_taken = eq;
      isa_pkg::BR_NE:   br_taken = !eq;
      isa_pkg::BR_LT:   br_taken = lt;
      isa_pkg::BR_GE:   br_taken = !lt;
      isa_pkg::BR_LTU:  br_taken = ltu;
      isa_pkg::BR_GEU:  br_taken = !ltu;
      isa_pkg::BR_JAL,
      isa_pkg::BR_JALR: br_taken = 1'b1;
      default:          br_taken = 1'b0;
    endcase
  end

  assign br_target = (ctrl.br_op == isa_pkg::BR_JALR) ? {alu_result[31:1], 1'b0} : pc + imm;

endmodule

/* design/idu.sv */
`timescale 1ns/1ps

module idu (
  input  isa_pkg::inst_t inst,
  output isa_pkg::ctrl_t ctrl,
  output logic [31:0]    imm
);

  logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  logic        sign;

  function automatic isa_pkg::alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? isa_pkg::ALU_SUB : isa_pkg::ALU_ADD;
      3'b001:  return isa_pkg::ALU_SLL;
      3'b010:  return isa_pkg::ALU_SLT;
      3'b011:  return isa_pkg::ALU_SLTU;
      3'b100:  return isa_pkg::ALU_XOR;
      3'b101:  return alt ? isa_pkg::ALU_SRA : isa_pkg::ALU_SRL;
      3'b110:  return isa_pkg::ALU_OR;
      default: return isa_pkg::ALU_AND;
    endcase
  endfunction

  assign sign  = inst.i.imm[11];
  assign imm_i = {{20{sign}}, inst.i.imm};
  assign imm_s = {{20{sign}}, inst.i.imm[11:5], inst.i.rd};
  assign imm_b = {{19{sign}}, sign, inst.i.rd[0], inst.i.imm[10:5], inst.i.rd[4:1], 1'b0};
  assign imm_u = {inst.i.imm, inst.i.rs1, inst.i.funct3, 12'b0};
  assign imm_j = {{11{sign}}, sign, inst.i.rs1, inst.i.funct3, inst.i.imm[0],
                  inst.i.imm[10:1], 1'b0};

  always_comb begin
    ctrl               = '0;  // unknown opcode is a no-op
    ctrl.rs1           = inst.r.rs1;
    ctrl.rs2           = inst.r.rs2;
    ctrl.rd            = inst.r.rd;
    ctrl.alu_op        = isa_pkg::ALU_ADD;
    ctrl.br_op         = isa_pkg::BR_NONE;
    ctrl.wb_sel        = isa_pkg::WB_ALU;
    ctrl.size          = inst.r.funct3[1:0];
    ctrl.unsigned_load = inst.r.funct3[2];
    imm                = imm_i;
    case (inst.r.opcode)
      isa_pkg::OP_LUI: begin
        ctrl.alu_op   = isa_pkg::ALU_SRC2;
        ctrl.src2_imm = 1'b1;
        ctrl.reg_we   = 1'b1;
        imm           = imm_u;
      end
      isa_pkg::OP_AUIPC: begin
        ctrl.src1_pc  = 1'b1;
        ctrl.src2_imm = 1'b1;
        ctrl.reg_we   = 1'b1;
        imm           = imm_u;
      end
      isa_pkg::OP_JAL: begin
        ctrl.br_op  = isa_pkg::BR_JAL;
        ctrl.wb_sel = isa_pkg::WB_PC4;
        ctrl.reg_we = 1'b1;
        imm         = imm_j;
      end
      isa_pkg::OP_JALR: begin
        ctrl.br_op    = isa_pkg::BR_JALR;
        ctrl.wb_sel   = isa_pkg::WB_PC4;
        ctrl.src2_imm = 1'b1;
        ctrl.reg_we   = 1'b1;
      end
      isa_pkg::OP_BRANCH: begin
        imm = imm_b;
        case (inst.r.funct3)
          3'b000:  ctrl.br_op = isa_pkg::BR_EQ;
          3'b001:  ctrl.br_op = isa_pkg::BR_NE;
          3'b100:  ctrl.br_op = isa_pkg::BR_LT;
          3'b101:  ctrl.br_op = isa_pkg::BR_GE;
          3'b110:  ctrl.br_op = isa_pkg::BR_LTU;
          3'b111:  ctrl.br_op = isa_pkg::BR_GEU;
          default: ctrl.br_op = isa_pkg::BR_NONE;
        endcase
      end
      isa_pkg::OP_LOAD: begin
        ctrl.src2_imm = 1'b1;
        ctrl.mem_rd   = 1'b1;
        ctrl.reg_we   = 1'b1;
        ctrl.wb_sel   = isa_pkg::WB_LOAD;
      end
      isa_pkg::OP_STORE: begin
        ctrl.src2_imm = 1'b1;
        ctrl.mem_wr   = 1'b1;
        imm           = imm_s;
      end
      isa_pkg::OP_IMM: begin
        // funct7 bit only matters for srai
        ctrl.alu_op   = alu_decode(inst.r.funct3,
                                   inst.r.funct7[5] && inst.r.funct3 == 3'b101);
        ctrl.src2_imm = 1'b1;
        ctrl.reg_we   = 1'b1;
      end
      isa_pkg::OP_REG: begin
        ctrl.alu_op = alu_decode(inst.r.funct3, inst.r.funct7[5]);
        ctrl.reg_we = 1'b1;
      end
      isa_pkg::OP_SYSTEM: ctrl.halt = (inst.i.imm == 12'h001);  // ebreak only
      default: ;
    endcase
  end

endmodule

/* design/ifu.sv */
`timescale 1ns/1ps

module ifu #(
  parameter logic [31:0] RESET_PC = 32'h8000_0000
) (
  input  logic              clk,
  input  logic              rst_n,
  output mem_pkg::mem_req_t fetch_req,
  input  logic              fetch_grant,
  input  mem_pkg::mem_rsp_t fetch_rsp,
  output isa_pkg::inst_t    inst,
  output logic [31:0]       pc,
  input  isa_pkg::ctrl_t    ctrl,
  input  logic              br_taken,
  input  logic [31:0]       br_target,
  input  logic              lsu_done,
  input  logic [31:0]       wb_data,    // alu result
  input  logic [31:0]       load_data,
  output logic              lsu_start,
  output mem_pkg::retire_t  retire,
  output logic              halted
);

  typedef enum logic [2:0] {
    S_IDLE, S_FETCH, S_WAIT, S_EXEC, S_MEM, S_HALT
  } state_e;

  state_e         state;
  logic [31:0]    pc_q, pc_plus4, next_pc;
  isa_pkg::inst_t inst_q;
  logic           is_mem, retire_now;

  assign pc_plus4   = pc_q + 32'd4;
  assign next_pc    = br_taken ? br_target : pc_plus4;
  assign is_mem     = ctrl.mem_rd | ctrl.mem_wr;
  assign retire_now = (state == S_EXEC && !is_mem) || (state == S_MEM && lsu_done);
  assign lsu_start  = (state == S_EXEC) && is_mem;
  assign halted     = (state == S_HALT);
  assign inst       = inst_q;
  assign pc         = pc_q;

  always_comb begin
    fetch_req       = '0;
    fetch_req.valid = (state == S_FETCH);  // held until granted
    fetch_req.addr  = pc_q;
  end

  always_comb begin
    retire.valid = retire_now;
    retire.pc    = pc_q;
    retire.rd    = ctrl.rd;
    retire.we    = ctrl.reg_we;
    case (ctrl.wb_sel)
      isa_pkg::WB_PC4:  retire.wdata = pc_plus4;
      isa_pkg::WB_LOAD: retire.wdata = load_data;
      default:          retire.wdata = wb_data;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= S_IDLE;
      pc_q  <= RESET_PC;
    end else begin
      if (retire_now) pc_q <= next_pc;
      case (state)
        S_IDLE:  state <= S_FETCH;
        S_FETCH: if (fetch_grant) state <= S_WAIT;
        S_WAIT:  if (fetch_rsp.valid) state <= S_EXEC;
        S_EXEC: begin
          if (is_mem) state <= S_MEM;
          else if (ctrl.halt) state <= S_HALT;  // ebreak
          else state <= S_FETCH;
        end
        S_MEM:   if (lsu_done) state <= S_FETCH;
        default: state <= S_HALT;  // stays until reset
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_WAIT && fetch_rsp.valid) inst_q <= fetch_rsp.rdata;
  end

endmodule

/* common/mem_pkg.sv */
package mem_pkg;

  typedef struct packed {
    logic        valid;
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } mem_req_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [4:0]  rd;
    logic        we;
    logic [31:0] wdata;
  } retire_t;

endpackage

/* common/isa_pkg.sv */
package isa_pkg;

  localparam int XLEN = 32;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  // rd slot doubles as imm[4:0] for S and B
  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } inst_t;

  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
    ALU_SRC2  // pass operand 2 through
  } alu_op_e;

  // nine kinds, so one bit wider than three
  typedef enum logic [3:0] {
    BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JAL, BR_JALR
  } br_op_e;

  typedef enum logic [1:0] {
    WB_ALU, WB_LOAD, WB_PC4
  } wb_sel_e;

  typedef struct packed {
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] rd;
    alu_op_e    alu_op;
    logic       src1_pc;
    logic       src2_imm;
    br_op_e     br_op;
    wb_sel_e    wb_sel;
    logic       reg_we;
    logic       mem_rd;
    logic       mem_wr;
    logic [1:0] size;           // 0 byte, 1 half, 2 word
    logic       unsigned_load;
    logic       halt;
  } ctrl_t;

endpackage
